// ==== logic/video_pkg.sv ====
package video_pkg;

	////////////////////
	// Screen geometry
	////////////////////

	typedef logic [8:0] screen_x_t;
	typedef logic [7:0] screen_y_t;

	////////////////////
	// Colour
	////////////////////

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef logic [1:0] bg_sel_t;

	// Cycles from pixel_valid to out_valid
	localparam int pipe_latency = 3;

	// Flat background colours, indexed by bg_sel_t
	localparam rgb_t bg_colors [4] = '{
		24'h10_20_40,
		24'h30_60_30,
		24'h60_30_50,
		24'h80_80_80
	};

endpackage

// ==== logic/sprite_pkg.sv ====
package sprite_pkg;

	////////////////////
	// Sprite set
	////////////////////

	localparam int num_sprites = 4;

	typedef logic [1:0] sprite_idx_t;

	// Ten bits so a sprite can hang off the right edge
	typedef logic [9:0] sprite_x_t;
	typedef logic [8:0] sprite_y_t;

	////////////////////
	// Shape and colour
	////////////////////

	localparam int sprite_size = 16;

	typedef logic [3:0] sprite_ofs_t;

	// One fixed colour per sprite, sprite 0 first
	localparam video_pkg::rgb_t sprite_colors [num_sprites] = '{
		24'hff_20_20,
		24'h20_ff_20,
		24'h20_40_ff,
		24'hff_e0_10
	};

	// Shared 16x16 mask, one hex row per line
	localparam string sprite_mask_file = "sprite.mem";

endpackage

// ==== logic/sprite_regs.sv ====
`timescale 1ns/10ps

module sprite_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    load_pos,
	input  logic                    load_att,
	input  sprite_pkg::sprite_idx_t sprite_sel,
	input  sprite_pkg::sprite_x_t   x,
	input  sprite_pkg::sprite_y_t   y,
	input  logic                    visable,
	input  logic                    bchange_active,
	input  video_pkg::bg_sel_t      background_sel,
	output sprite_pkg::sprite_x_t   spr_x [sprite_pkg::num_sprites],
	output sprite_pkg::sprite_y_t   spr_y [sprite_pkg::num_sprites],
	output logic [sprite_pkg::num_sprites-1:0] spr_visible,
	output video_pkg::bg_sel_t      bg_sel
);

	import sprite_pkg::*;

	logic [num_sprites-1:0] sel_dec;

	// One-hot select, shared by both strobes
	always_comb begin
		sel_dec = '0;
		sel_dec[sprite_sel] = 1'b1;
	end

	////////////////////
	// Sprite attributes
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_sprites; i++) begin
				spr_x[i] <= '0;
				spr_y[i] <= '0;
			end
			spr_visible <= '0;
		end else begin
			for (int i = 0; i < num_sprites; i++) begin
				if (load_pos && sel_dec[i]) begin
					spr_x[i] <= x;
					spr_y[i] <= y;
				end
				if (load_att && sel_dec[i]) begin
					spr_visible[i] <= visable;
				end
			end
		end
	end

	// Background choice
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bg_sel <= '0;
		end else if (bchange_active) begin
			bg_sel <= background_sel;
		end
	end

endmodule

// ==== logic/sprite_unit.sv ====
`timescale 1ns/10ps

module sprite_unit #(
	parameter video_pkg::rgb_t color = '0
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  video_pkg::screen_x_t  pixel_x,
	input  video_pkg::screen_y_t  pixel_y,
	input  logic                  pixel_valid,
	input  sprite_pkg::sprite_x_t pos_x,
	input  sprite_pkg::sprite_y_t pos_y,
	input  logic                  visible,
	output logic                  obj_on,
	output video_pkg::rgb_t       obj_rgb,
	output logic                  hit_valid
);

	import sprite_pkg::*;

	logic [sprite_size-1:0] mask [sprite_size];

	// One bit wider than either operand, so a negative difference never wraps into range
	logic [10:0] dx;
	logic [9:0]  dy;
	logic        in_box;

	logic        s1_hit;
	logic        s1_valid;
	sprite_ofs_t s1_ofs_x;
	sprite_ofs_t s1_ofs_y;
	logic [sprite_size-1:0] mask_row;

	initial begin
		$readmemh(sprite_mask_file, mask);
	end

	////////////////////
	// Stage 1
	////////////////////

	assign dx = {2'b00, pixel_x} - {1'b0, pos_x};
	assign dy = {2'b00, pixel_y} - {1'b0, pos_y};
	assign in_box = visible && (dx < 11'(sprite_size)) && (dy < 10'(sprite_size));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_hit   <= 1'b0;
			s1_valid <= 1'b0;
		end else begin
			s1_hit   <= pixel_valid && in_box;
			s1_valid <= pixel_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_ofs_x <= sprite_ofs_t'(dx);
		s1_ofs_y <= sprite_ofs_t'(dy);
	end

	////////////////////
	// Stage 2
	////////////////////

	// Bit 15 holds column 0
	assign mask_row = mask[s1_ofs_y];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			obj_on    <= 1'b0;
			hit_valid <= 1'b0;
		end else begin
			obj_on    <= s1_hit && mask_row[~s1_ofs_x];
			hit_valid <= s1_valid;
		end
	end

	assign obj_rgb = color;

endmodule

// ==== logic/layer_mixer.sv ====
`timescale 1ns/10ps

module layer_mixer (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [sprite_pkg::num_sprites-1:0] obj_on,
	input  video_pkg::rgb_t                    obj_rgb [sprite_pkg::num_sprites],
	input  logic                               hit_valid,
	input  video_pkg::bg_sel_t                 bg_sel,
	output logic [7:0]                         pixel_r,
	output logic [7:0]                         pixel_g,
	output logic [7:0]                         pixel_b,
	output logic                               out_valid
);

	import video_pkg::*;
	import sprite_pkg::*;

	rgb_t mix_rgb;
	rgb_t out_rgb;

	////////////////////
	// Priority select
	////////////////////

	// Walk from the top so the lowest active sprite is written last
	always_comb begin
		mix_rgb = bg_colors[bg_sel];
		for (int i = num_sprites - 1; i >= 0; i--) begin
			if (obj_on[i]) begin
				mix_rgb = obj_rgb[i];
			end
		end
	end

	////////////////////
	// Output stage
	////////////////////

	// Colour holds between pixels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_rgb   <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= hit_valid;
			if (hit_valid) begin
				out_rgb <= mix_rgb;
			end
		end
	end

	assign pixel_r = out_rgb.r;
	assign pixel_g = out_rgb.g;
	assign pixel_b = out_rgb.b;

endmodule

// ==== logic/sprite_compositor.sv ====
`timescale 1ns/10ps

module sprite_compositor (
	input  logic                    clk,
	input  logic                    rst_n,
	input  video_pkg::screen_x_t    pixel_x,
	input  video_pkg::screen_y_t    pixel_y,
	input  logic                    pixel_valid,
	input  logic                    load_pos,
	input  logic                    load_att,
	input  sprite_pkg::sprite_idx_t sprite_sel,
	input  sprite_pkg::sprite_x_t   x,
	input  sprite_pkg::sprite_y_t   y,
	input  logic                    visable,
	input  logic                    bchange_active,
	input  video_pkg::bg_sel_t      background_sel,
	output logic [7:0]              pixel_r,
	output logic [7:0]              pixel_g,
	output logic [7:0]              pixel_b,
	output logic                    out_valid
);

	import video_pkg::*;
	import sprite_pkg::*;

	// Fixed latency of pipe_latency cycles, two in the units and one in the mixer

	sprite_x_t              spr_x [num_sprites];
	sprite_y_t              spr_y [num_sprites];
	logic [num_sprites-1:0] spr_visible;
	bg_sel_t                bg_sel;

	logic [num_sprites-1:0] obj_on;
	rgb_t                   obj_rgb [num_sprites];
	logic [num_sprites-1:0] hit_valid;

	sprite_regs sprite_regs_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.load_pos       (load_pos),
		.load_att       (load_att),
		.sprite_sel     (sprite_sel),
		.x              (x),
		.y              (y),
		.visable        (visable),
		.bchange_active (bchange_active),
		.background_sel (background_sel),
		.spr_x          (spr_x),
		.spr_y          (spr_y),
		.spr_visible    (spr_visible),
		.bg_sel         (bg_sel)
	);

	for (genvar i = 0; i < num_sprites; i++) begin : g_sprite
		sprite_unit #(
			.color (sprite_colors[i])
		) sprite_unit_i (
			.clk         (clk),
			.rst_n       (rst_n),
			.pixel_x     (pixel_x),
			.pixel_y     (pixel_y),
			.pixel_valid (pixel_valid),
			.pos_x       (spr_x[i]),
			.pos_y       (spr_y[i]),
			.visible     (spr_visible[i]),
			.obj_on      (obj_on[i]),
			.obj_rgb     (obj_rgb[i]),
			.hit_valid   (hit_valid[i])
		);
	end

	// Units run in lockstep, sprite 0 speaks for all
	layer_mixer layer_mixer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.obj_on    (obj_on),
		.obj_rgb   (obj_rgb),
		.hit_valid (hit_valid[0]),
		.bg_sel    (bg_sel),
		.pixel_r   (pixel_r),
		.pixel_g   (pixel_g),
		.pixel_b   (pixel_b),
		.out_valid (out_valid)
	);

endmodule

// ==== dv/tb_sprite_compositor.sv ====
`timescale 1ns/10ps

module tb_sprite_compositor;

	import video_pkg::*;
	import sprite_pkg::*;

	// Summed scan lengths in cycles with four per pixel for the gap scan
	localparam int scan_cycles = 16*8 + 4*(8*4) + 18*18 + 3*(26*24) + 4*(20*10);
	localparam int timeout_cycles = scan_cycles + 200;

	logic        clk = 1'b0;
	logic        rst_n;
	screen_x_t   pixel_x;
	screen_y_t   pixel_y;
	logic        pixel_valid;
	logic        load_pos;
	logic        load_att;
	sprite_idx_t sprite_sel;
	sprite_x_t   x;
	sprite_y_t   y;
	logic        visable;
	logic        bchange_active;
	bg_sel_t     background_sel;
	logic [7:0]  pixel_r;
	logic [7:0]  pixel_g;
	logic [7:0]  pixel_b;
	logic        out_valid;

	// Reference model state
	logic [15:0] mask_rom [16];
	int          ref_x [num_sprites];
	int          ref_y [num_sprites];
	bit          ref_vis [num_sprites];
	int          ref_bg;
	rgb_t        exp_q [$];
	rgb_t        popped;
	logic [pipe_latency-1:0] valid_hist;
	int          cycle_count = 0;
	string       test_name = "none";

	sprite_compositor sprite_compositor_i (.*);

	always #20 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	// Writes position and visibility together and mirrors them in the model
	task automatic set_sprite(input int idx, input int sx, input int sy, input bit vis);
		sprite_sel = sprite_idx_t'(idx);
		x = sprite_x_t'(sx);
		y = sprite_y_t'(sy);
		visable = vis;
		load_pos = 1'b1;
		load_att = 1'b1;
		ref_x[idx] = sx;
		ref_y[idx] = sy;
		ref_vis[idx] = vis;
		step();
		load_pos = 1'b0;
		load_att = 1'b0;
	endtask

	task automatic set_background(input int b);
		background_sel = bg_sel_t'(b);
		bchange_active = 1'b1;
		ref_bg = b;
		step();
		bchange_active = 1'b0;
	endtask

	// First covering sprite in index order wins
	function automatic rgb_t expected_color(input int px, input int py);
		rgb_t c;
		int dx;
		int dy;
		bit found;
		c = bg_colors[ref_bg];
		found = 1'b0;
		for (int i = 0; i < num_sprites; i++) begin
			dx = px - ref_x[i];
			dy = py - ref_y[i];
			if (!found && ref_vis[i] && dx >= 0 && dx < 16 && dy >= 0 && dy < 16) begin
				if (mask_rom[dy][15 - dx]) begin
					c = sprite_colors[i];
					found = 1'b1;
				end
			end
		end
		return c;
	endfunction

	task automatic scan_area(input int x0, input int y0, input int w, input int h, input bit gaps);
		int n;
		for (int yy = 0; yy < h; yy++) begin
			for (int xx = 0; xx < w; xx++) begin
				pixel_x = screen_x_t'(x0 + xx);
				pixel_y = screen_y_t'(y0 + yy);
				pixel_valid = 1'b1;
				step();
				pixel_valid = 1'b0;
				if (gaps) begin
					n = $urandom % 4;
					repeat (n) step();
				end
			end
		end
		while (exp_q.size() != 0) step();
	endtask

	////////////////////
	// Checking
	////////////////////

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_hist <= '0;
		end else begin
			valid_hist <= {valid_hist[pipe_latency-2:0], pixel_valid};
		end
	end

	always @(posedge clk) begin
		if (rst_n && pixel_valid) begin
			exp_q.push_back(expected_color(int'(pixel_x), int'(pixel_y)));
		end
	end

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			assert (out_valid === valid_hist[pipe_latency-1])
			else fail_run($sformatf("mismatch test=%s out_valid expected=%b actual=%b",
				test_name, valid_hist[pipe_latency-1], out_valid));
			if (out_valid) begin
				popped = exp_q.pop_front();
				assert ({pixel_r, pixel_g, pixel_b} === popped)
				else fail_run($sformatf("mismatch test=%s expected=%06h actual=%06h",
					test_name, popped, {pixel_r, pixel_g, pixel_b}));
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			fail_run($sformatf("run did not finish within %0d cycles", timeout_cycles));
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int bx;
		int by;
		int sx;
		int sy;
		int idx;
		void'($urandom(32'hcfc0));
		rst_n = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		pixel_valid = 1'b0;
		load_pos = 1'b0;
		load_att = 1'b0;
		sprite_sel = '0;
		x = '0;
		y = '0;
		visable = 1'b0;
		bchange_active = 1'b0;
		background_sel = '0;
		ref_bg = 0;
		for (int i = 0; i < num_sprites; i++) begin
			ref_x[i] = 0;
			ref_y[i] = 0;
			ref_vis[i] = 1'b0;
		end
		$readmemh("sprite.mem", mask_rom);
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		test_name = "reset_idle";
		repeat (5) step();
		scan_area(0, 0, 16, 8, 1'b0);

		test_name = "backgrounds";
		for (int b = 0; b < 4; b++) begin
			set_background(b);
			scan_area(100 + 8*b, 40, 8, 4, 1'b0);
		end

		// One-pixel margin reaches past every sprite edge
		test_name = "single_sprite";
		idx = $urandom % num_sprites;
		sx = 1 + $urandom % 470;
		sy = 1 + $urandom % 220;
		set_sprite(idx, sx, sy, 1'b1);
		scan_area(sx - 1, sy - 1, 18, 18, 1'b0);
		set_sprite(idx, sx, sy, 1'b0);

		test_name = "overlap";
		bx = 1 + $urandom % 460;
		by = 1 + $urandom % 210;
		for (int i = 0; i < num_sprites; i++) begin
			set_sprite(i, bx + 3*i, by + 2*i, 1'b1);
		end
		scan_area(bx - 1, by - 1, 26, 24, 1'b0);
		test_name = "overlap_hide0";
		set_sprite(0, bx, by, 1'b0);
		scan_area(bx - 1, by - 1, 26, 24, 1'b0);
		test_name = "overlap_hide1";
		set_sprite(1, bx + 3, by + 2, 1'b0);
		scan_area(bx - 1, by - 1, 26, 24, 1'b0);

		test_name = "valid_gaps";
		set_background(2);
		scan_area(bx, by + 4, 20, 10, 1'b1);

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== sprite.mem ====
// One 16-bit hex row per line, row 0 first
// Bit 15 of each row is column 0
03C0
0FF0
1FF8
3FFC
7FFE
7E7E
FC3F
FC3F
FFFF
FFFF
7FFE
7FFE
3DBC
1818
0990
8001

// ==== filelist.f ====
logic/video_pkg.sv
logic/sprite_pkg.sv
logic/sprite_regs.sv
logic/sprite_unit.sv
logic/layer_mixer.sv
logic/sprite_compositor.sv
dv/tb_sprite_compositor.sv

// ==== Makefile ====
SRCS := $(shell cat filelist.f)

.PHONY: run clean

obj_dir/Vtb_sprite_compositor: filelist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_sprite_compositor -f filelist.f

run: obj_dir/Vtb_sprite_compositor
	./obj_dir/Vtb_sprite_compositor | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
